// File: deparser_pkg.sv
package deparser_pkg;

    parameter int data_w = 256;
    parameter int keep_w = data_w / 8;
    parameter int user_w = 32;

    parameter int num_actions = 4;
    parameter int num_containers = 4;

    // vlan slice of the first beat that picks the table entry
    parameter int table_index_lsb = 120;
    parameter int table_index_w = 4;

    // control header fields in the wide control format
    parameter int cfg_id_lsb = 368;
    parameter int cfg_flag_lsb = 320;
    parameter int cfg_index_lsb = 384;
    parameter logic [15:0] cfg_flag = 16'hf2f1;

    // same fields folded into one 256-bit control beat
    parameter int cfg_id_pos = cfg_id_lsb % data_w;
    parameter int cfg_flag_pos = cfg_flag_lsb % data_w;
    parameter int cfg_index_pos = cfg_index_lsb % data_w;

    // action width codes
    parameter logic [1:0] width_2b = 2'd1;
    parameter logic [1:0] width_4b = 2'd2;
    parameter logic [1:0] width_6b = 2'd3;

    typedef struct packed {
        logic [data_w-1:0] tdata;
        logic [keep_w-1:0] tkeep;
        logic [user_w-1:0] tuser;
        logic              tlast;
    } axis_beat_t;

    typedef struct packed {
        logic [data_w-1:0] tdata;
        logic              tvalid;
        logic              tlast;
    } ctrl_beat_t;

    typedef struct packed {
        logic [num_containers-1:0][15:0] c2;
        logic [num_containers-1:0][31:0] c4;
        logic [num_containers-1:0][47:0] c6;
    } phv_t;

    // valid sits in bit 0 of each 16-bit action
    typedef struct packed {
        logic [5:0]                        rsvd;
        logic [$clog2(keep_w)-1:0]         offset;
        logic [$clog2(num_containers)-1:0] container;
        logic [1:0]                        width;
        logic                              valid;
    } deparse_action_t;

    // action 0 in the low 16 bits
    typedef struct packed {
        deparse_action_t [num_actions-1:0] act;
    } action_entry_t;

    typedef struct packed {
        logic [data_w-1:0] value;
        logic [keep_w-1:0] mask;
    } field_write_t;

endpackage

// File: deparse_action_table.sv
`timescale 1ns/1ps

module deparse_action_table
    import deparser_pkg::*;
#(
    parameter logic [2:0] module_id = 3'b101,
    parameter int table_depth = 16
) (
    input  logic                     clk,
    input  logic                     aresetn,
    input  ctrl_beat_t               c_s_axis,
    input  logic [table_index_w-1:0] rd_index,
    output action_entry_t            rd_entry
);

    localparam int ptr_w = $clog2(table_depth);

    typedef enum logic {
        c_idle,
        c_write
    } c_state_t;

    c_state_t         c_state;
    logic [ptr_w-1:0] wr_ptr;
    action_entry_t    mem [table_depth];

    logic [2:0]       hdr_id;
    logic [15:0]      hdr_flag;
    logic [ptr_w-1:0] hdr_index;
    logic             hdr_match;
    action_entry_t    wr_entry;

    // only the low three bits of the id byte name a module
    assign hdr_id = c_s_axis.tdata[cfg_id_pos +: 3];
    assign hdr_flag = c_s_axis.tdata[cfg_flag_pos +: 16];
    assign hdr_index = c_s_axis.tdata[cfg_index_pos +: ptr_w];

    assign hdr_match = c_s_axis.tvalid && (hdr_id == module_id) && (hdr_flag == cfg_flag);

    // entries are taken in arrival byte order
    assign wr_entry = c_s_axis.tdata[$bits(action_entry_t)-1:0];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            c_state <= c_idle;
            wr_ptr <= '0;
            for (int i = 0; i < table_depth; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (c_state)
                c_idle: begin
                    // any beat may be a header, including one that ends a packet
                    if (hdr_match) begin
                        wr_ptr <= hdr_index;
                        c_state <= c_write;
                    end
                end
                c_write: begin
                    if (c_s_axis.tvalid) begin
                        mem[wr_ptr] <= wr_entry;
                        wr_ptr <= wr_ptr + 1'b1;
                        if (c_s_axis.tlast) begin
                            c_state <= c_idle;
                        end
                    end
                end
                default: begin
                    c_state <= c_idle;
                end
            endcase
        end
    end

    // read port registered one cycle after rd_index
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_index];
    end

endmodule

// File: phv_field_extract.sv
`timescale 1ns/1ps

module phv_field_extract
    import deparser_pkg::*;
(
    input  logic            clk,
    input  logic            aresetn,
    input  phv_t            phv,
    input  deparse_action_t action,
    output field_write_t    field
);

    logic [47:0]       cont;
    logic [2:0]        nbytes;
    logic [data_w-1:0] next_value;
    logic [keep_w-1:0] next_mask;

    // container left aligned so its msb byte is always bits 47..40
    always_comb begin
        cont = '0;
        nbytes = 3'd0;
        case (action.width)
            width_2b: begin
                cont = {phv.c2[action.container], 32'h0};
                nbytes = 3'd2;
            end
            width_4b: begin
                cont = {phv.c4[action.container], 16'h0};
                nbytes = 3'd4;
            end
            width_6b: begin
                cont = phv.c6[action.container];
                nbytes = 3'd6;
            end
            default: begin
                cont = '0;
                nbytes = 3'd0;
            end
        endcase
    end

    always_comb begin
        int lane;
        next_value = '0;
        next_mask = '0;
        for (int b = 0; b < 6; b++) begin
            lane = int'(action.offset) + b;
            // bytes past the end of the beat are dropped
            if (action.valid && (b < int'(nbytes)) && (lane < keep_w)) begin
                next_value[lane*8 +: 8] = cont[47 - 8*b -: 8];
                next_mask[lane] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            field <= '0;
        end else begin
            field.value <= next_value;
            field.mask <= next_mask;
        end
    end

endmodule

// File: deparser_engine.sv
`timescale 1ns/1ps

module deparser_engine
    import deparser_pkg::*;
(
    input  logic                              clk,
    input  logic                              aresetn,

    input  axis_beat_t                        pkt_fifo_head,
    input  logic                              pkt_fifo_empty,
    output logic                              pkt_fifo_rd_en,

    input  phv_t                              phv_fifo_out,
    input  logic                              phv_fifo_empty,
    output logic                              phv_fifo_rd_en,

    output phv_t                              captured_phv,
    output logic [table_index_w-1:0]          lookup_index,
    input  field_write_t [num_actions-1:0]    fields,

    output axis_beat_t                        depar_out,
    output logic                              depar_out_tvalid,
    input  logic                              depar_out_tready
);

    typedef enum logic [2:0] {
        s_idle,
        s_lookup,
        s_extract,
        s_rewrite,
        s_header,
        s_stream
    } state_t;

    state_t            state;
    axis_beat_t        beat_q;
    logic              pkt_pop_q;
    logic              start;
    logic              out_xfer;
    logic [data_w-1:0] merged;

    assign start = (state == s_idle) && !pkt_fifo_empty && !phv_fifo_empty;
    assign out_xfer = depar_out_tvalid && depar_out_tready;

    // later actions overwrite earlier ones on shared bytes
    always_comb begin
        merged = beat_q.tdata;
        for (int a = 0; a < num_actions; a++) begin
            for (int k = 0; k < keep_w; k++) begin
                if (fields[a].mask[k]) begin
                    merged[k*8 +: 8] = fields[a].value[k*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state <= s_idle;
            pkt_pop_q <= 1'b0;
            phv_fifo_rd_en <= 1'b0;
        end else begin
            pkt_pop_q <= start;
            // phv stays at the head until the header beat is built
            phv_fifo_rd_en <= (state == s_rewrite);
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_lookup;
                    end
                end
                // table read in flight
                s_lookup: begin
                    state <= s_extract;
                end
                // extractors registering
                s_extract: begin
                    state <= s_rewrite;
                end
                s_rewrite: begin
                    state <= s_header;
                end
                s_header: begin
                    if (depar_out_tready) begin
                        state <= beat_q.tlast ? s_idle : s_stream;
                    end
                end
                s_stream: begin
                    if (out_xfer && pkt_fifo_head.tlast) begin
                        state <= s_idle;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            beat_q <= pkt_fifo_head;
            captured_phv <= phv_fifo_out;
            lookup_index <= pkt_fifo_head.tdata[table_index_lsb +: table_index_w];
        end else if (state == s_rewrite) begin
            beat_q.tdata <= merged;
        end
    end

    // after the header, the fifo head goes straight out
    assign depar_out = (state == s_stream) ? pkt_fifo_head : beat_q;

    assign depar_out_tvalid = (state == s_header) ||
                              ((state == s_stream) && !pkt_fifo_empty);

    assign pkt_fifo_rd_en = (state == s_stream) ? out_xfer : pkt_pop_q;

endmodule

// File: deparser.sv
`timescale 1ns/1ps

module deparser
    import deparser_pkg::*;
#(
    parameter logic [2:0] module_id = 3'b101,
    parameter int table_depth = 16
) (
    input  logic       clk,
    input  logic       aresetn,

    input  axis_beat_t pkt_fifo_head,
    input  logic       pkt_fifo_empty,
    output logic       pkt_fifo_rd_en,

    input  phv_t       phv_fifo_out,
    input  logic       phv_fifo_empty,
    output logic       phv_fifo_rd_en,

    output axis_beat_t depar_out,
    output logic       depar_out_tvalid,
    input  logic       depar_out_tready,

    input  ctrl_beat_t c_s_axis
);

    logic [table_index_w-1:0]       lookup_index;
    action_entry_t                  rd_entry;
    phv_t                           captured_phv;
    field_write_t [num_actions-1:0] fields;

    deparse_action_table #(
        .module_id   (module_id),
        .table_depth (table_depth)
    ) u_table (
        .clk      (clk),
        .aresetn  (aresetn),
        .c_s_axis (c_s_axis),
        .rd_index (lookup_index),
        .rd_entry (rd_entry)
    );

    // one extractor per action slot
    for (genvar i = 0; i < num_actions; i++) begin : g_extract
        phv_field_extract u_extract (
            .clk     (clk),
            .aresetn (aresetn),
            .phv     (captured_phv),
            .action  (rd_entry.act[i]),
            .field   (fields[i])
        );
    end

    deparser_engine u_engine (
        .clk              (clk),
        .aresetn          (aresetn),
        .pkt_fifo_head    (pkt_fifo_head),
        .pkt_fifo_empty   (pkt_fifo_empty),
        .pkt_fifo_rd_en   (pkt_fifo_rd_en),
        .phv_fifo_out     (phv_fifo_out),
        .phv_fifo_empty   (phv_fifo_empty),
        .phv_fifo_rd_en   (phv_fifo_rd_en),
        .captured_phv     (captured_phv),
        .lookup_index     (lookup_index),
        .fields           (fields),
        .depar_out        (depar_out),
        .depar_out_tvalid (depar_out_tvalid),
        .depar_out_tready (depar_out_tready)
    );

endmodule

// File: deparser_properties.sv
`timescale 1ns/1ps

module deparser_properties
    import deparser_pkg::*;
(
    input logic       clk,
    input logic       aresetn,
    input logic       pkt_fifo_empty,
    input logic       pkt_fifo_rd_en,
    input logic       phv_fifo_empty,
    input logic       phv_fifo_rd_en,
    input axis_beat_t depar_out,
    input logic       depar_out_tvalid,
    input logic       depar_out_tready
);

    // fwft pops only while a word is at the head
    pkt_rd_not_empty: assert property (
        @(posedge clk) disable iff (!aresetn) pkt_fifo_rd_en |-> !pkt_fifo_empty
    ) else $error("packet fifo read while empty");

    phv_rd_not_empty: assert property (
        @(posedge clk) disable iff (!aresetn) phv_fifo_rd_en |-> !phv_fifo_empty
    ) else $error("phv fifo read while empty");

    // stalled beat must hold
    out_stable: assert property (
        @(posedge clk) disable iff (!aresetn)
        (depar_out_tvalid && !depar_out_tready) |=> (depar_out_tvalid && $stable(depar_out))
    ) else $error("output beat changed while stalled");

    phv_single_pop: assert property (
        @(posedge clk) disable iff (!aresetn) phv_fifo_rd_en |=> !phv_fifo_rd_en
    ) else $error("phv fifo read on two consecutive cycles");

endmodule

// File: tb_deparser.sv
`timescale 1ns/1ps

module tb_deparser
    import deparser_pkg::*;
;

    logic         clk;
    logic         aresetn;
    ctrl_beat_t   c_s_axis;
    axis_beat_t   pkt_fifo_head = '0;
    logic         pkt_fifo_empty = 1'b1;
    logic         pkt_fifo_rd_en;
    phv_t         phv_fifo_out = '0;
    logic         phv_fifo_empty = 1'b1;
    logic         phv_fifo_rd_en;
    axis_beat_t   depar_out;
    logic         depar_out_tvalid;
    logic         depar_out_tready = 1'b1;

    axis_beat_t   pkt_q[$];
    phv_t         phv_q[$];
    axis_beat_t   exp_q[$];
    ctrl_beat_t   ctrl_q[$];
    logic         fifo_en = 1'b0;
    logic [31:0]  lfsr = 32'h78ed991d;
    int           errors = 0;
    int           drain_errors = 0;
    int           exp_idx = 0;
    int           cycles = 0;
    int           cycle_limit = 100000;

    deparser #(
        .module_id   (3'b101),
        .table_depth (16)
    ) u_dut (
        .clk              (clk),
        .aresetn          (aresetn),
        .pkt_fifo_head    (pkt_fifo_head),
        .pkt_fifo_empty   (pkt_fifo_empty),
        .pkt_fifo_rd_en   (pkt_fifo_rd_en),
        .phv_fifo_out     (phv_fifo_out),
        .phv_fifo_empty   (phv_fifo_empty),
        .phv_fifo_rd_en   (phv_fifo_rd_en),
        .depar_out        (depar_out),
        .depar_out_tvalid (depar_out_tvalid),
        .depar_out_tready (depar_out_tready),
        .c_s_axis         (c_s_axis)
    );

    bind deparser deparser_properties u_props (
        .clk              (clk),
        .aresetn          (aresetn),
        .pkt_fifo_empty   (pkt_fifo_empty),
        .pkt_fifo_rd_en   (pkt_fifo_rd_en),
        .phv_fifo_empty   (phv_fifo_empty),
        .phv_fifo_rd_en   (phv_fifo_rd_en),
        .depar_out        (depar_out),
        .depar_out_tvalid (depar_out_tvalid),
        .depar_out_tready (depar_out_tready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // fills the queues from the tagged records and counts them
    task automatic read_stimulus(output int records);
        int fd;
        int code;
        string line;
        logic [7:0] tag;
        logic [383:0] v1;
        logic [383:0] v2;
        logic [383:0] v3;
        logic [383:0] v4;
        axis_beat_t b;
        ctrl_beat_t c;
        records = 0;
        fd = $fopen("deparser_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open deparser_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%c %h %h %h %h", tag, v1, v2, v3, v4);
                    records++;
                    b.tlast = v1[0];
                    b.tkeep = v2[keep_w-1:0];
                    b.tuser = v3[user_w-1:0];
                    b.tdata = v4[data_w-1:0];
                    case (tag)
                        "C": begin
                            c.tdata = v2[data_w-1:0];
                            c.tvalid = 1'b1;
                            c.tlast = v1[0];
                            ctrl_q.push_back(c);
                        end
                        "P": pkt_q.push_back(b);
                        "E": exp_q.push_back(b);
                        "H": phv_q.push_back(v1);
                        default: begin
                            errors++;
                            $display("unknown record tag in stimulus file");
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_beat(input axis_beat_t got, input axis_beat_t exp, input int n);
        assert (got.tdata == exp.tdata) else begin
            errors++;
            $display("CHECK FAILED depar_out.tdata beat %0d: got %h expected %h",
                     n, got.tdata, exp.tdata);
        end
        assert (got.tkeep == exp.tkeep) else begin
            errors++;
            $display("CHECK FAILED depar_out.tkeep beat %0d: got %h expected %h",
                     n, got.tkeep, exp.tkeep);
        end
        assert (got.tuser == exp.tuser) else begin
            errors++;
            $display("CHECK FAILED depar_out.tuser beat %0d: got %h expected %h",
                     n, got.tuser, exp.tuser);
        end
        assert (got.tlast == exp.tlast) else begin
            errors++;
            $display("CHECK FAILED depar_out.tlast beat %0d: got %h expected %h",
                     n, got.tlast, exp.tlast);
        end
    endtask

    // fwft models whose head and empty move on the clock edge
    always @(posedge clk) begin
        if (pkt_fifo_rd_en && pkt_q.size() > 0) begin
            void'(pkt_q.pop_front());
        end
        if (phv_fifo_rd_en && phv_q.size() > 0) begin
            void'(phv_q.pop_front());
        end
        pkt_fifo_empty <= !fifo_en || (pkt_q.size() == 0);
        pkt_fifo_head <= (pkt_q.size() > 0) ? pkt_q[0] : '0;
        phv_fifo_empty <= !fifo_en || (phv_q.size() == 0);
        phv_fifo_out <= (phv_q.size() > 0) ? phv_q[0] : '0;
    end

    // output monitor and tready held high until the first beat is out
    always @(posedge clk) begin
        if (aresetn && depar_out_tvalid && depar_out_tready) begin
            assert (exp_idx < exp_q.size()) else begin
                errors++;
                $display("output beat arrived after all expected beats were seen");
            end
            if (exp_idx < exp_q.size()) begin
                check_beat(depar_out, exp_q[exp_idx], exp_idx);
            end
            exp_idx++;
        end
        lfsr = lfsr_step(lfsr);
        depar_out_tready <= (exp_idx == 0) || lfsr[0];
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d beats seen",
                 cycle_limit, exp_idx, exp_q.size());
        $display("Test failures found");
        $finish;
    end

    initial begin
        int records;
        aresetn = 1'b0;
        c_s_axis = '0;
        read_stimulus(records);
        cycle_limit = 40 * records + 10;
        repeat (10) @(posedge clk);
        aresetn <= 1'b1;
        // table is configured before any packet is released
        foreach (ctrl_q[i]) begin
            @(posedge clk);
            c_s_axis <= ctrl_q[i];
        end
        @(posedge clk);
        c_s_axis <= '0;
        @(posedge clk);
        fifo_en <= 1'b1;
        while (exp_idx < exp_q.size()) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        assert (pkt_q.size() == 0 && phv_q.size() == 0) else begin
            drain_errors++;
            $display("fifos not drained: %0d packet beats and %0d phvs left",
                     pkt_q.size(), phv_q.size());
        end
        $display("%0d beats checked, %0d errors", exp_idx, errors + drain_errors);
        if (errors + drain_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: deparser_stim.txt
# C: tlast tdata | P and E: tlast tkeep tuser tdata | H: phv (c2, c4, c6 from the top)
# C beats configure the table first; E beats are the output in order
C 0 1000500000000f2f10000000000000000
C 0 3cf00850003
C 1 860084
C 0 1000300000000f2f10000000000000000
C 1 85
C 0 1000500000000f2f00000000000000000
C 1 85
C 0 3000500000000f2f10000000000000000
C 1 13b010d
P 1 ffffffff 00000011 3f3e3d3c3b3a39383736353433323130012e2d2c2b2a29282726252423222120
H 3333222211110a0b444433334444222244441111a1a2a3a4f1f2f3f4f5f6e1e2e3e4e5e6d1d2d3d4d5d6b1b2b3b4b5b6
E 1 ffffffff 00000011 d2d13d3c3b3a39383736353433323130012e2d2c2b2a2928a4a3a2a123220b0a
P 0 ffffffff 00000022 3f3e3d3c3b3a39383736353433323130012e2d2c2b2a29282726252423222120
P 0 ffffffff 00000023 5a5a5a5a
P 1 0000ffff 00000024 a5a5
H 3333222211110a0b444433334444222244441111a1a2a3a4f1f2f3f4f5f6e1e2e3e4e5e6d1d2d3d4d5d6b1b2b3b4b5b6
E 0 ffffffff 00000022 d2d13d3c3b3a39383736353433323130012e2d2c2b2a2928a4a3a2a123220b0a
E 0 ffffffff 00000023 5a5a5a5a
E 1 0000ffff 00000024 a5a5
P 1 ffffffff 00000033 3f3e3d3c3b3a39383736353433323130022e2d2c2b2a29282726252423222120
H 3333222211110a0b444433334444222244441111a1a2a3a4f1f2f3f4f5f6e1e2e3e4e5e6d1d2d3d4d5d6b1b2b3b4b5b6
E 1 ffffffff 00000033 3f3e3d3c3b3a39383736353433323130022e2d2c2b2a29282726252423222120
P 1 ffffffff 00000044 3f3e3d3c3b3a39383736353433323130012e2d2c2b2a29282726252423222120
H 3333222211110a0b444433334444222244441111a1a2a3a4f1f2f3f4f5f6e1e2e3e4e5e6d1d2d3d4d5d6b1b2b3b4b5b6
E 1 ffffffff 00000044 d2d13d3c3b3a39383736353433323130012e2d2c2b2a2928a4a3a2a123220b0a
P 1 ffffffff 00000055 3f3e3d3c3b3a39383736353433323130032e2d2c2b2a29282726252423222120
H 3333222211110a0b444433334444222244441111a1a2a3a4f1f2f3f4f5f6e1e2e3e4e5e6d1d2d3d4d5d6b1b2b3b4b5b6
E 1 ffffffff 00000055 3f3e3d3c3b3a39383736353433323130032e2d2c113333442726252423222120
P 0 ffffffff 00000061 3f3e3d3c3b3a39383736353433323130002e2d2c2b2a29282726252423222120
P 1 0000000f 00000062 abcd
H 3333222211110a0b444433334444222244441111a1a2a3a4f1f2f3f4f5f6e1e2e3e4e5e6d1d2d3d4d5d6b1b2b3b4b5b6
E 0 ffffffff 00000061 3f3e3d3c3b3a39383736353433323130002e2d2c2b2a29282726252423222120
E 1 0000000f 00000062 abcd
P 1 ffffffff 00000063 3f3e3d3c3b3a39383736353433323130032e2d2c2b2a29282726252423222120
H 3333222211110a0b444433334444222244441111a1a2a3a4f1f2f3f4f5f6e1e2e3e4e5e6d1d2d3d4d5d6b1b2b3b4b5b6
E 1 ffffffff 00000063 3f3e3d3c3b3a39383736353433323130032e2d2c113333442726252423222120

// File: tb.f
deparser_pkg.sv
deparse_action_table.sv
phv_field_extract.sv
deparser_engine.sv
deparser.sv
deparser_properties.sv
tb_deparser.sv

// File: Makefile
.PHONY: compile run clean

compile: obj_dir/Vtb_deparser

obj_dir/Vtb_deparser: tb.f $(wildcard *.sv)
	verilator --binary --timing --assert -f tb.f --top-module tb_deparser -Mdir obj_dir

run: compile
	./obj_dir/Vtb_deparser | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
